/* vlog.f */
shader_pkg.sv
ray_id_pool.sv
pixel_id_ram.sv
result_arbiter.sv
valid_stall_pipe.sv
result_fifo.sv
shader_unit.sv
tb_clock_gen.sv
tb_shader_unit.sv

/* tb_shader_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_shader_unit
  import shader_pkg::*;
;

  localparam int CLK_PERIOD      = 4;
  localparam int WATCHDOG_CYCLES = 2 * (64 + 40 * 300);  // load plus 300 rays, doubled

  logic          clk;
  logic          rst_n;
  logic          prg_valid, prg_stall;
  prg_ray_t      prg_data;
  logic          pcalc_valid, pcalc_stall;
  pcalc_result_t pcalc_data;
  logic          int_valid, int_stall;
  int_result_t   int_data;
  logic          sint_valid, sint_stall;
  sint_result_t  sint_data;
  logic          ss_valid, ss_stall;
  ss_result_t    ss_data;
  logic          pb_we, pb_full;
  pixel_entry_t  pb_data;
  logic          trace_valid, trace_stall;
  trace_req_t    trace_data;
  logic          raystore_we;
  ray_id_t       raystore_addr;
  ray_vec_t      raystore_data;

  int            seed;
  int            n_checks;
  int            n_errors;
  int            delivered;
  pixel_id_t     exp_pix [NUM_RAYS];   // scoreboard, ray id to pixel
  logic          id_busy [NUM_RAYS];
  pixel_id_t     pend_pix [$];         // results not yet seen at the pixel buffer
  color_t        pend_col [$];
  pixel_id_t     cur_pix;
  ray_vec_t      cur_vec;

  tb_clock_gen u_clk (.clk(clk));

  shader_unit uut (.*);

  // ----------------------------------------------------------
  // checker and expected colours
  // ----------------------------------------------------------
  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // src 0 pcalc, 1 int, 2 sint, 3 ss
  function automatic color_t exp_color(input int src, input tri_id_t tri_idx, input logic shadow);
    case (src)
      0: begin
        case (tri_idx)
          16'd0:   return TRI0_COLOR;
          16'd1:   return TRI1_COLOR;
          16'd2:   return TRI2_COLOR;
          16'd3:   return TRI3_COLOR;
          default: return UNKNOWN_TRI_COLOR;
        endcase
      end
      1:       return SHADOW_HIT_COLOR;   // shadow ray blocked
      2:       return BB_MISS_COLOR;
      default: return shadow ? SHADOW_MISS_COLOR : MISS_COLOR;
    endcase
  endfunction

  function automatic logic src_stall(input int src);
    case (src)
      0:       return pcalc_stall;
      1:       return int_stall;
      2:       return sint_stall;
      default: return ss_stall;
    endcase
  endfunction

  // ----------------------------------------------------------
  // ray intake helpers
  // ----------------------------------------------------------
  task automatic drive_ray(input pixel_id_t pix, input ray_vec_t vec);
    @(negedge clk);
    cur_pix   = pix;
    cur_vec   = vec;
    prg_valid = 1'b1;
    prg_data  = '{pixel_id: pix, ray_vec: vec};
  endtask

  // called at a falling edge with the ray already presented
  task automatic accept_ray(output ray_id_t id);
    #1;
    while (prg_stall) begin
      @(negedge clk);
      #1;
    end
    id = trace_data.ray_id;
    check("trace_valid", trace_valid, 1'b1);
    check("raystore_we", raystore_we, 1'b1);
    check("raystore_addr", raystore_addr, id);
    check("raystore_data", raystore_data, cur_vec);
    check("trace_data.ray_vec", trace_data.ray_vec, cur_vec);
    check("trace_data.is_shadow", trace_data.is_shadow, 1'b0);
    check("ray id already in flight", id_busy[id], 1'b0);
    id_busy[id] = 1'b1;
    exp_pix[id] = cur_pix;
    @(negedge clk);
    prg_valid = 1'b0;
  endtask

  task automatic send_ray(output ray_id_t id);
    ray_vec_t vec;
    vec = {$random(seed), $random(seed), $random(seed)};
    drive_ray(pixel_id_t'($random(seed)), vec);
    accept_ray(id);
  endtask

  // ----------------------------------------------------------
  // result source helpers
  // ----------------------------------------------------------
  task automatic drive_source(input int src, input logic valid, input ray_id_t id,
                              input tri_id_t tri_idx, input logic shadow);
    case (src)
      0: begin
        pcalc_valid = valid;
        pcalc_data  = '{ray_id: id, tri_id: tri_idx};
      end
      1: begin
        int_valid = valid;
        int_data  = '{ray_id: id};
      end
      2: begin
        sint_valid = valid;
        sint_data  = '{ray_id: id, is_shadow: shadow};
      end
      default: begin
        ss_valid = valid;
        ss_data  = '{ray_id: id, is_shadow: shadow};
      end
    endcase
  endtask

  task automatic send_result(input int src, input ray_id_t id, input tri_id_t tri_idx,
                             input logic shadow);
    pend_pix.push_back(exp_pix[id]);
    pend_col.push_back(exp_color(src, tri_idx, shadow));
    id_busy[id] = 1'b0;
    @(negedge clk);
    drive_source(src, 1'b1, id, tri_idx, shadow);
    #1;
    while (src_stall(src)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    drive_source(src, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (pend_pix.size() != 0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (pend_pix.size() != 0) begin
      n_errors++;
      $display("Error at %0t ns: %0d results never reached the pixel buffer",
               $time, pend_pix.size());
      pend_pix.delete();
      pend_col.delete();
    end
    repeat (4) @(negedge clk);  // stray writes still show up
  endtask

  // pixel buffer writes, matched against pending results as a set
  always @(negedge clk) begin : pb_monitor
    int idx;
    #1;
    if (rst_n && pb_we) begin
      delivered++;
      idx = -1;
      for (int i = 0; i < pend_pix.size(); i++) begin
        if (idx < 0 && pend_pix[i] == pb_data.pixel_id && pend_col[i] == pb_data.color) begin
          idx = i;
        end
      end
      for (int i = 0; i < pend_pix.size(); i++) begin
        if (idx < 0 && pend_pix[i] == pb_data.pixel_id) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        n_errors++;
        $display("Error at %0t ns: pixel buffer write for pixel %0h that no result expects",
                 $time, pb_data.pixel_id);
      end else begin
        check("pb_data.color", pb_data.color, pend_col[idx]);
        pend_pix.delete(idx);
        pend_col.delete(idx);
      end
    end
  end

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic reset_and_load();
    ray_id_t id;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    // a ray already waits while the pool is still empty
    drive_ray(pixel_id_t'($random(seed)), {$random(seed), $random(seed), $random(seed)});
    rst_n = 1'b1;
    #1;
    check("trace_valid after reset", trace_valid, 1'b0);
    check("raystore_we after reset", raystore_we, 1'b0);
    check("pb_we after reset", pb_we, 1'b0);
    check("prg_stall after reset", prg_stall, 1'b1);
    @(negedge clk);
    accept_ray(id);
    check("first loaded ray id", id, ray_id_t'(0));
  endtask

  task automatic issue_all_ids();
    ray_id_t id;
    for (int i = 1; i < NUM_RAYS; i++) begin  // id 0 went out during the load
      send_ray(id);
    end
  endtask

  // every id is out, so the next ray must wait for a result
  task automatic reuse_freed_id();
    ray_id_t id;
    drive_ray(pixel_id_t'($random(seed)), {$random(seed), $random(seed), $random(seed)});
    repeat (10) begin
      #1;
      check("prg_stall with no free id", prg_stall, 1'b1);
      check("raystore_we with no free id", raystore_we, 1'b0);
      @(negedge clk);
    end
    send_result(3, 6'd17, '0, 1'b1);
    accept_ray(id);
    check("reused ray id", id, 6'd17);
  endtask

  task automatic shade_every_source();
    int      src;
    tri_id_t tri_idx;
    for (int i = 0; i < NUM_RAYS; i++) begin
      src     = i % 4;
      tri_idx = (i < 48) ? tri_id_t'((i / 4) % 6) : tri_id_t'($random(seed));
      send_result(src, ray_id_t'(i), tri_idx, 1'((i / 4) % 2));  // ss alternates shadow
    end
    wait_drain(500);
  endtask

  task automatic hold_pixel_buffer();
    ray_id_t ids [8];
    int      held;
    for (int i = 0; i < 8; i++) begin
      send_ray(ids[i]);
    end
    @(negedge clk);
    pb_full = 1'b1;
    held    = delivered;
    // fifo, pipe stage and arbiter register take six between them
    for (int i = 0; i < 6; i++) begin
      send_result(i % 4, ids[i], tri_id_t'(i), i[0]);
    end
    repeat (12) @(negedge clk);
    check("pb writes while pb_full", delivered, held);
    check("results queued under pb_full", pend_pix.size(), 6);
    pb_full = 1'b0;
    send_result(0, ids[6], 16'd9, 1'b0);
    send_result(3, ids[7], '0, 1'b0);
    wait_drain(200);
    check("pb writes after release", delivered - held, 8);
  endtask

  task automatic stall_trace_engine();
    ray_id_t id;
    @(negedge clk);
    trace_stall = 1'b1;
    drive_ray(pixel_id_t'($random(seed)), {$random(seed), $random(seed), $random(seed)});
    repeat (6) begin
      #1;
      check("prg_stall under trace_stall", prg_stall, 1'b1);
      check("raystore_we under trace_stall", raystore_we, 1'b0);
      @(negedge clk);
    end
    trace_stall = 1'b0;
    accept_ray(id);
    send_result(0, id, 16'd3, 1'b0);
    wait_drain(100);
  endtask

  task automatic race_all_sources();
    ray_id_t ids [8];
    for (int i = 0; i < 8; i++) begin
      send_ray(ids[i]);
    end
    for (int r = 0; r < 2; r++) begin
      fork
        send_result(0, ids[4*r], tri_id_t'(r + 1), 1'b0);
        send_result(1, ids[4*r+1], '0, 1'b1);
        send_result(2, ids[4*r+2], '0, 1'b0);
        send_result(3, ids[4*r+3], '0, 1'(r));
      join
    end
    wait_drain(200);
  endtask

  // ----------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------
  initial begin
    seed        = 6;
    n_checks    = 0;
    n_errors    = 0;
    delivered   = 0;
    rst_n       = 1'b0;
    prg_valid   = 1'b0;
    prg_data    = '0;
    pcalc_valid = 1'b0;
    pcalc_data  = '0;
    int_valid   = 1'b0;
    int_data    = '0;
    sint_valid  = 1'b0;
    sint_data   = '0;
    ss_valid    = 1'b0;
    ss_data     = '0;
    pb_full     = 1'b0;
    trace_stall = 1'b0;
    for (int i = 0; i < NUM_RAYS; i++) begin
      id_busy[i] = 1'b0;
      exp_pix[i] = '0;
    end

    reset_and_load();
    issue_all_ids();
    reuse_freed_id();
    shade_every_source();
    hold_pixel_buffer();
    stall_trace_engine();
    race_all_sources();

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD = 2  // 4 ns period
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

/* shader_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module shader_unit
  import shader_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst_n,

  input  wire logic    prg_valid,
  input  prg_ray_t     prg_data,
  output logic         prg_stall,

  input  wire logic    pcalc_valid,
  input  pcalc_result_t pcalc_data,
  output logic         pcalc_stall,

  input  wire logic    int_valid,
  input  int_result_t  int_data,
  output logic         int_stall,

  input  wire logic    sint_valid,
  input  sint_result_t sint_data,
  output logic         sint_stall,

  input  wire logic    ss_valid,
  input  ss_result_t   ss_data,
  output logic         ss_stall,

  output logic         pb_we,
  input  wire logic    pb_full,
  output pixel_entry_t pb_data,

  output logic         trace_valid,
  output trace_req_t   trace_data,
  input  wire logic    trace_stall,

  output logic         raystore_we,
  output ray_id_t      raystore_addr,
  output ray_vec_t     raystore_data
);

  ray_id_t      head_id;
  logic         pool_empty;
  logic         pool_loading;
  logic         prg_accept;
  pixel_id_t    ram_rdata;

  logic [3:0]       arb_valid_us;
  logic [3:0]       arb_stall_us;
  shade_req_t [3:0] arb_data_us;
  logic             arb_valid_ds;
  logic             arb_stall_ds;
  shade_req_t       arb_data_ds;

  logic         pipe_us_stall;
  logic         pipe_ds_valid;
  shade_req_t   pipe_ds_data;
  logic [2:0]   fifo_free;
  logic         fifo_empty;
  shade_entry_t fifo_wdata;
  shade_entry_t fifo_rdata;

  // ----------------------------------------------------------
  // ray intake, zero cycle path to the trace engine
  // ----------------------------------------------------------
  assign prg_stall   = trace_stall | pool_empty;
  assign trace_valid = prg_valid & ~pool_empty;
  assign prg_accept  = prg_valid & ~prg_stall;

  always_comb begin
    trace_data.ray_id    = head_id;
    trace_data.is_shadow = 1'b0;          // primary rays only
    trace_data.ray_vec   = prg_data.ray_vec;
  end

  assign raystore_we   = prg_accept;
  assign raystore_addr = head_id;
  assign raystore_data = prg_data.ray_vec;

  // id freed once its pixel is read at the pipe output
  ray_id_pool u_pool (
    .clk, .rst_n,
    .push    (pipe_ds_valid),
    .push_id (pipe_ds_data.ray_id),
    .pop     (prg_accept),
    .head_id (head_id),
    .empty   (pool_empty),
    .loading (pool_loading)
  );

  pixel_id_ram u_ram (
    .clk,
    .we    (prg_accept),
    .waddr (head_id),
    .wdata (prg_data.pixel_id),
    .raddr (pipe_ds_data.ray_id),
    .rdata (ram_rdata)
  );

  // ----------------------------------------------------------
  // result mapping into the arbiter
  // ----------------------------------------------------------
  always_comb begin
    arb_data_us[0] = '{ray_id: pcalc_data.ray_id, tri_id: pcalc_data.tri_id,
                       is_hit: 1'b1, bb_miss: 1'b0, is_shadow: 1'b0};
    arb_data_us[1] = '{ray_id: int_data.ray_id, tri_id: '0,
                       is_hit: 1'b1, bb_miss: 1'b0, is_shadow: 1'b1};
    arb_data_us[2] = '{ray_id: sint_data.ray_id, tri_id: '0,
                       is_hit: 1'b0, bb_miss: 1'b1, is_shadow: sint_data.is_shadow};
    arb_data_us[3] = '{ray_id: ss_data.ray_id, tri_id: '0,
                       is_hit: 1'b0, bb_miss: 1'b0, is_shadow: ss_data.is_shadow};
  end

  assign arb_valid_us = {ss_valid, sint_valid, int_valid, pcalc_valid};
  assign pcalc_stall  = arb_stall_us[0];
  assign int_stall    = arb_stall_us[1];
  assign sint_stall   = arb_stall_us[2];
  assign ss_stall     = arb_stall_us[3];

  // held off while the pool is still filling
  assign arb_stall_ds = pipe_us_stall | pool_loading;

  result_arbiter u_arb (
    .clk, .rst_n,
    .valid_us (arb_valid_us),
    .data_us  (arb_data_us),
    .stall_us (arb_stall_us),
    .valid_ds (arb_valid_ds),
    .data_ds  (arb_data_ds),
    .stall_ds (arb_stall_ds)
  );

  valid_stall_pipe u_pipe (
    .clk, .rst_n,
    .us_valid   (arb_valid_ds & ~pool_loading),
    .us_data    (arb_data_ds),
    .us_stall   (pipe_us_stall),
    .ds_valid   (pipe_ds_valid),
    .ds_data    (pipe_ds_data),
    .free_slots (fifo_free)
  );

  // ----------------------------------------------------------
  // pixel lookup and output queue
  // ----------------------------------------------------------
  always_comb begin
    fifo_wdata.pixel_id  = ram_rdata;
    fifo_wdata.tri_id    = pipe_ds_data.tri_id;
    fifo_wdata.is_hit    = pipe_ds_data.is_hit;
    fifo_wdata.bb_miss   = pipe_ds_data.bb_miss;
    fifo_wdata.is_shadow = pipe_ds_data.is_shadow;
  end

  result_fifo u_fifo (
    .clk, .rst_n,
    .we         (pipe_ds_valid),
    .wdata      (fifo_wdata),
    .re         (pb_we),
    .rdata      (fifo_rdata),
    .empty      (fifo_empty),
    .free_slots (fifo_free)
  );

  assign pb_we = ~fifo_empty & ~pb_full;

  function automatic color_t calc_color(shade_entry_t e);
    color_t c;
    casez ({e.bb_miss, e.is_shadow, e.is_hit})
      3'b1??:  c = BB_MISS_COLOR;
      3'b010:  c = SHADOW_MISS_COLOR;
      3'b000:  c = MISS_COLOR;
      3'b011:  c = SHADOW_HIT_COLOR;
      default: begin                  // plain hit, colour by triangle
        case (e.tri_id)
          16'd0:   c = TRI0_COLOR;
          16'd1:   c = TRI1_COLOR;
          16'd2:   c = TRI2_COLOR;
          16'd3:   c = TRI3_COLOR;
          default: c = UNKNOWN_TRI_COLOR;
        endcase
      end
    endcase
    return c;
  endfunction

  always_comb begin
    pb_data.pixel_id = fifo_rdata.pixel_id;
    pb_data.color    = calc_color(fifo_rdata);
  end

endmodule

`default_nettype wire

/* result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module result_fifo
  import shader_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  we,
  input  shade_entry_t wdata,
  input  wire logic  re,
  output shade_entry_t rdata,
  output logic       empty,
  output logic [2:0] free_slots
);

  shade_entry_t mem [RESULT_FIFO_DEPTH];

  logic [$clog2(RESULT_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(RESULT_FIFO_DEPTH)-1:0] rd_ptr;
  logic [2:0]                           count;
  logic                                 full;
  logic                                 do_wr;
  logic                                 do_rd;

  assign full  = (count == 3'(RESULT_FIFO_DEPTH));
  assign empty = (count == '0);
  assign do_wr = we & ~full;    // pipe reserves a slot ahead of time
  assign do_rd = re & ~empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // ----------------------------------------------------------
  // pointers and count
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign rdata      = mem[rd_ptr];                   // head, shown while not empty
  assign free_slots = 3'(RESULT_FIFO_DEPTH) - count;

endmodule

`default_nettype wire

/* valid_stall_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module valid_stall_pipe
  import shader_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       us_valid,
  input  shade_req_t      us_data,
  output logic            us_stall,
  output logic            ds_valid,
  output shade_req_t      ds_data,
  input  wire logic [2:0] free_slots
);

  logic [PIPE_DEPTH-1:0] stage_valid;
  shade_req_t            stage_data [PIPE_DEPTH];
  logic [PIPE_DEPTH-1:0] open;        // stage can take an item this cycle
  logic [2:0]            in_flight;   // items already bound for the fifo
  logic                  room;

  // last stage writes the fifo every cycle it is valid,
  // so entry into it needs a slot beyond what is already going in
  assign in_flight = {2'b00, stage_valid[PIPE_DEPTH-1]};
  assign room      = free_slots > in_flight;

  always_comb begin
    open[PIPE_DEPTH-1] = room;
    for (int k = PIPE_DEPTH - 2; k >= 0; k--) begin
      open[k] = ~stage_valid[k] | open[k+1];
    end
  end

  assign us_stall = ~open[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= '0;
    end else begin
      if (open[0]) begin
        stage_valid[0] <= us_valid;
      end
      for (int k = 1; k < PIPE_DEPTH - 1; k++) begin
        if (open[k]) begin
          stage_valid[k] <= stage_valid[k-1];
        end
      end
      stage_valid[PIPE_DEPTH-1] <= room & stage_valid[PIPE_DEPTH-2];  // drains always
    end
  end

  always_ff @(posedge clk) begin
    if (open[0]) begin
      stage_data[0] <= us_data;
    end
    for (int k = 1; k < PIPE_DEPTH; k++) begin
      if (open[k]) begin
        stage_data[k] <= stage_data[k-1];
      end
    end
  end

  assign ds_valid = stage_valid[PIPE_DEPTH-1];
  assign ds_data  = stage_data[PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* result_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module result_arbiter
  import shader_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [3:0]  valid_us,
  input  shade_req_t [3:0] data_us,
  output logic [3:0]       stall_us,
  output logic             valid_ds,
  output shade_req_t       data_ds,
  input  wire logic        stall_ds
);

  logic [1:0] last;     // previous winner
  logic [1:0] win;
  logic       found;
  logic [3:0] grant;
  logic       load;     // output reg empty or draining

  // ----------------------------------------------------------
  // round robin search, starting after last winner
  // ----------------------------------------------------------
  always_comb begin
    logic [1:0] idx;
    win   = last;
    found = 1'b0;
    for (int i = 1; i <= 4; i++) begin
      idx = last + 2'(i);
      if (!found && valid_us[idx]) begin
        found = 1'b1;
        win   = idx;
      end
    end
  end

  always_comb begin
    grant      = '0;
    grant[win] = found;
  end

  assign load     = ~valid_ds | ~stall_ds;
  assign stall_us = ~(grant & {4{load}});   // losers and held inputs stall

  // ----------------------------------------------------------
  // output register
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_ds <= 1'b0;
      last     <= 2'd3;                      // input 0 goes first
    end else if (load) begin
      valid_ds <= found;
      if (found) begin
        last <= win;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && found) begin
      data_ds <= data_us[win];
    end
  end

endmodule

`default_nettype wire

/* pixel_id_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_id_ram
  import shader_pkg::*;
(
  input  wire logic clk,
  input  wire logic we,
  input  ray_id_t   waddr,
  input  pixel_id_t wdata,
  input  ray_id_t   raddr,
  output pixel_id_t rdata
);

  // one pixel per ray id
  pixel_id_t mem [NUM_RAYS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // async read, looked up in the same cycle the pipe presents the id
  assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* ray_id_pool.sv */
`timescale 1ns/1ps
`default_nettype none

module ray_id_pool
  import shader_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic push,
  input  ray_id_t   push_id,
  input  wire logic pop,
  output ray_id_t   head_id,
  output logic      empty,
  output logic      loading
);

  ray_id_t mem [NUM_RAYS];

  ray_id_t             wr_ptr;
  ray_id_t             rd_ptr;
  logic [RAY_ID_W:0]   count;    // 0 .. NUM_RAYS
  ray_id_t             load_cnt;

  logic    wr_en;
  logic    rd_en;
  ray_id_t wr_data;

  // ----------------------------------------------------------
  // write side, fill from counter during load
  // ----------------------------------------------------------
  assign wr_en   = loading | push;              // push ignored while loading
  assign wr_data = loading ? load_cnt : push_id;
  assign rd_en   = pop & ~empty;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loading  <= 1'b1;
      load_cnt <= '0;
    end else if (loading) begin
      load_cnt <= load_cnt + 1'b1;
      if (load_cnt == ray_id_t'(NUM_RAYS - 1)) begin
        loading <= 1'b0;                         // every id written once
      end
    end
  end

  // ----------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at NUM_RAYS
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ids are unique so count never passes NUM_RAYS
  assign empty   = (count == '0);
  assign head_id = mem[rd_ptr];

endmodule

`default_nettype wire

/* shader_pkg.sv */
`default_nettype none

package shader_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  localparam int NUM_RAYS          = 64;              // ray ids in flight
  localparam int RAY_ID_W          = $clog2(NUM_RAYS);
  localparam int RESULT_FIFO_DEPTH = 4;
  localparam int PIPE_DEPTH        = 2;

  typedef logic [RAY_ID_W-1:0] ray_id_t;
  typedef logic [15:0]         pixel_id_t;
  typedef logic [15:0]         tri_id_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } color_t;

  // fixed point, 16 bits per component
  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] z;
  } vec3_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_vec_t;

  // ----------------------------------------------------------
  // link payloads
  // ----------------------------------------------------------
  typedef struct packed {
    pixel_id_t pixel_id;
    ray_vec_t  ray_vec;
  } prg_ray_t;

  typedef struct packed {
    ray_id_t  ray_id;
    logic     is_shadow;
    ray_vec_t ray_vec;
  } trace_req_t;

  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
  } pcalc_result_t;

  typedef struct packed {
    ray_id_t ray_id;
  } int_result_t;

  typedef struct packed {
    ray_id_t ray_id;
    logic    is_shadow;
  } sint_result_t;

  typedef struct packed {
    ray_id_t ray_id;
    logic    is_shadow;
  } ss_result_t;

  // arbiter and pipe payload
  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
    logic    is_hit;
    logic    bb_miss;
    logic    is_shadow;
  } shade_req_t;

  // result fifo payload, ray id already swapped for its pixel
  typedef struct packed {
    pixel_id_t pixel_id;
    tri_id_t   tri_id;
    logic      is_hit;
    logic      bb_miss;
    logic      is_shadow;
  } shade_entry_t;

  typedef struct packed {
    pixel_id_t pixel_id;
    color_t    color;
  } pixel_entry_t;

  // ----------------------------------------------------------
  // colours
  // ----------------------------------------------------------
  localparam color_t MISS_COLOR        = 24'h203040;
  localparam color_t TRI0_COLOR        = 24'hff0000;  // red
  localparam color_t TRI1_COLOR        = 24'h00ff00;  // green
  localparam color_t TRI2_COLOR        = 24'hffff00;  // yellow
  localparam color_t TRI3_COLOR        = 24'h00ffff;  // cyan
  localparam color_t SHADOW_HIT_COLOR  = 24'h0000ff;  // blue
  localparam color_t SHADOW_MISS_COLOR = 24'h808080;
  localparam color_t BB_MISS_COLOR     = 24'hff00ff;  // magenta
  localparam color_t UNKNOWN_TRI_COLOR = 24'h000000;

endpackage

`default_nettype wire
